// File: include/qam_defs.svh
`ifndef QAM_DEFS_SVH
`define QAM_DEFS_SVH

//////////////////////////////
// FIFO depths
//////////////////////////////

// All three depths must stay powers of two
`define QAM_IN_DEPTH	4
`define QAM_SYM_DEPTH	4
`define QAM_OUT_DEPTH	4

//////////////////////////////
// Field widths
//////////////////////////////

`define QAM_NIBBLE_W	4
`define QAM_PAIR_W	2
`define QAM_LEVEL_W	4

`endif

// File: hw/qamStreamPkg.sv
`include "qam_defs.svh"

package qamStreamPkg;

	// Two data bits that pick one axis level
	typedef logic [`QAM_PAIR_W-1:0] qamBitPair_t;

	// Data nibble, I pair in the upper half
	typedef logic [`QAM_NIBBLE_W-1:0] qamNibble_t;

	// Bits 3 and 2 select I
	function automatic qamBitPair_t iBits(input qamNibble_t nibble);
		return nibble[`QAM_NIBBLE_W-1 -: `QAM_PAIR_W];	// Upper pair
	endfunction

	// Bits 1 and 0 select Q
	function automatic qamBitPair_t qBits(input qamNibble_t nibble);
		return nibble[`QAM_PAIR_W-1:0];	// Lower pair
	endfunction

	// Rebuild a nibble from decided pairs
	function automatic qamNibble_t packNibble(input qamBitPair_t iPair, input qamBitPair_t qPair);
		return {iPair, qPair};	// I on top
	endfunction

endpackage

// File: hw/qamSymbolPkg.sv
`include "qam_defs.svh"

package qamSymbolPkg;

	// Signed axis amplitude, legal points are -3, -1, +1, +3
	typedef logic signed [`QAM_LEVEL_W-1:0] qamLevel_t;

	// One constellation point, I then Q
	typedef struct packed {
		qamLevel_t i;	// In-phase
		qamLevel_t q;	// Quadrature
	} qamSymbol_t;

	//////////////////////////////
	// Gray coding per axis
	//////////////////////////////

	// Bit pair to level, adjacent levels differ in one bit
	function automatic qamLevel_t grayToLevel(input qamStreamPkg::qamBitPair_t bitPair);
		qamLevel_t level;
		case (bitPair)
			2'b00:   level = qamLevel_t'(-3);	// Outer negative
			2'b01:   level = qamLevel_t'(-1);	// Inner negative
			2'b11:   level = qamLevel_t'(1);	// Inner positive
			default: level = qamLevel_t'(3);	// 2'b10, outer positive
		endcase
		return level;
	endfunction

	// Inverse of the table above, expects a decided level
	function automatic qamStreamPkg::qamBitPair_t levelToGray(input qamLevel_t level);
		qamStreamPkg::qamBitPair_t bitPair;
		case (level)
			-3:      bitPair = 2'b00;
			-1:      bitPair = 2'b01;
			1:       bitPair = 2'b11;
			default: bitPair = 2'b10;	// +3
		endcase
		return bitPair;
	endfunction

endpackage

// File: hw/syncFifo.sv
`timescale 1ns/1ps

module syncFifo #(
	parameter int  DEPTH     = 4,	// Power of two
	parameter type payload_t = logic [7:0]
) (
	input  logic     inClock,
	input  logic     rst,

	input  logic     inWriteEnable,	// Ignored while full
	input  payload_t inData,
	output logic     outFull,

	input  logic     inReadEnable,	// Pulse only while not empty
	output payload_t outData,	// Valid one cycle after the pulse
	output logic     outEmpty
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t         mem [DEPTH];	// Circular storage
	logic [PTR_W-1:0] wrPtr;	// Next slot to fill
	logic [PTR_W-1:0] rdPtr;	// Oldest entry
	logic [CNT_W-1:0] count;	// Entries held
	logic             doWrite;
	logic             doRead;

	//////////////////////////////
	// Qualified handshake
	//////////////////////////////

	assign doWrite  = inWriteEnable && !outFull;	// Drop writes when full
	assign doRead   = inReadEnable && !outEmpty;	// Guard against underflow
	assign outFull  = (count == CNT_W'(DEPTH));
	assign outEmpty = (count == '0);

	//////////////////////////////
	// Pointers and count
	//////////////////////////////

	always_ff @(posedge inClock) begin
		if (rst) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;	// Comes up empty
		end else begin
			if (doWrite) begin
				wrPtr <= wrPtr + 1'b1;	// Wraps at DEPTH
			end
			if (doRead) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doWrite, doRead})
				2'b10:   count <= count + 1'b1;	// Push only
				2'b01:   count <= count - 1'b1;	// Pop only
				default: count <= count;	// Both or neither
			endcase
		end
	end

	//////////////////////////////
	// Storage and read register
	//////////////////////////////

	always_ff @(posedge inClock) begin
		if (doWrite) begin
			mem[wrPtr] <= inData;
		end
		if (doRead) begin
			outData <= mem[rdPtr];	// Holds until the next pop
		end
	end

endmodule

// File: hw/qamMapper.sv
`timescale 1ns/1ps

module qamMapper (
	input  logic                     inClock,
	input  logic                     rst,

	input  qamStreamPkg::qamNibble_t inNibble,	// From nibble FIFO read port
	input  logic                     inEmpty,
	output logic                     outReadEnable,

	input  logic                     inFull,	// Symbol FIFO full
	output logic                     outWriteEnable,
	output qamSymbolPkg::qamSymbol_t outSymbol
);

	typedef enum logic {
		stateIdle,	// Nothing in hand
		stateHold	// Nibble on the read port
	} state_t;

	state_t state;
	state_t stateNext;
	logic   canTake;	// Free to pop this cycle

	//////////////////////////////
	// Pop then push control
	//////////////////////////////

	assign outWriteEnable = (state == stateHold) && !inFull;	// Stall on full sink
	assign canTake        = (state == stateIdle) || outWriteEnable;	// Pop overlaps push
	assign outReadEnable  = canTake && !inEmpty && !inFull;

	always_comb begin
		stateNext = state;
		case (state)
			stateIdle: begin
				if (outReadEnable) begin
					stateNext = stateHold;	// Data lands next cycle
				end
			end
			stateHold: begin
				if (outWriteEnable && !outReadEnable) begin
					stateNext = stateIdle;	// Pushed, nothing new
				end
			end
			default: stateNext = stateIdle;
		endcase
	end

	always_ff @(posedge inClock) begin
		if (rst) begin
			state <= stateIdle;
		end else begin
			state <= stateNext;
		end
	end

	//////////////////////////////
	// Gray lookup
	//////////////////////////////

	// Read register holds the nibble while stalled
	assign outSymbol.i = qamSymbolPkg::grayToLevel(qamStreamPkg::iBits(inNibble));
	assign outSymbol.q = qamSymbolPkg::grayToLevel(qamStreamPkg::qBits(inNibble));

endmodule

// File: hw/qamSlicer.sv
`timescale 1ns/1ps

module qamSlicer (
	input  logic                     inClock,
	input  logic                     rst,

	input  qamSymbolPkg::qamSymbol_t inSymbol,	// From symbol FIFO read port
	input  logic                     inEmpty,
	output logic                     outReadEnable,

	input  logic                     inFull,	// Output FIFO full
	output logic                     outWriteEnable,
	output qamStreamPkg::qamNibble_t outNibble,

	output logic                     outTxValid,	// One pulse per consumed symbol
	output qamSymbolPkg::qamLevel_t  outTxI,
	output qamSymbolPkg::qamLevel_t  outTxQ
);

	typedef enum logic {
		stateIdle,	// Nothing in hand
		stateHold	// Symbol on the read port
	} state_t;

	state_t                  state;
	state_t                  stateNext;
	logic                    canTake;
	logic                    popDone;	// Pop issued last cycle
	qamSymbolPkg::qamLevel_t decidedI;
	qamSymbolPkg::qamLevel_t decidedQ;

	// Nearest legal level, thresholds at -2, 0, +2
	function automatic qamSymbolPkg::qamLevel_t sliceLevel(input qamSymbolPkg::qamLevel_t rx);
		qamSymbolPkg::qamLevel_t decided;
		if (rx < -2)
			decided = qamSymbolPkg::qamLevel_t'(-3);
		else if (rx < 0)
			decided = qamSymbolPkg::qamLevel_t'(-1);	// -2 and -1
		else if (rx < 2)
			decided = qamSymbolPkg::qamLevel_t'(1);	// 0 and +1
		else
			decided = qamSymbolPkg::qamLevel_t'(3);
		return decided;
	endfunction

	//////////////////////////////
	// Pop then push control
	//////////////////////////////

	assign outWriteEnable = (state == stateHold) && !inFull;	// Stall on full sink
	assign canTake        = (state == stateIdle) || outWriteEnable;
	assign outReadEnable  = canTake && !inEmpty && !inFull;

	always_comb begin
		stateNext = state;
		case (state)
			stateIdle: if (outReadEnable) stateNext = stateHold;
			stateHold: if (outWriteEnable && !outReadEnable) stateNext = stateIdle;
			default:   stateNext = stateIdle;
		endcase
	end

	always_ff @(posedge inClock) begin
		if (rst) begin
			state   <= stateIdle;
			popDone <= 1'b0;
		end else begin
			state   <= stateNext;
			popDone <= outReadEnable;	// Marks the fresh symbol
		end
	end

	//////////////////////////////
	// Decision and Gray inverse
	//////////////////////////////

	assign decidedI  = sliceLevel(inSymbol.i);
	assign decidedQ  = sliceLevel(inSymbol.q);
	assign outNibble = qamStreamPkg::packNibble(qamSymbolPkg::levelToGray(decidedI),
		qamSymbolPkg::levelToGray(decidedQ));

	// Tap shows the symbol as received, once
	assign outTxValid = popDone;
	assign outTxI     = inSymbol.i;
	assign outTxQ     = inSymbol.q;

endmodule

// File: hw/qamLoopTop.sv
`timescale 1ns/1ps

`include "qam_defs.svh"

module qamLoopTop (
	input  logic                     inClock,
	input  logic                     rst,

	input  logic                     inWriteEnable,	// Nibble push
	input  qamStreamPkg::qamNibble_t inData,
	output logic                     outFull,	// Input queue full

	input  logic                     inReadEnable,	// Nibble pop
	output qamStreamPkg::qamNibble_t outData,
	output logic                     outEmpty,	// Output queue empty

	output logic                     outTxValid,	// Transmitted signal tap
	output qamSymbolPkg::qamLevel_t  outTxI,
	output qamSymbolPkg::qamLevel_t  outTxQ
);

	qamStreamPkg::qamNibble_t mapNibble;	// inFifo to mapper
	logic                     mapEmpty;
	logic                     mapReadEnable;
	qamSymbolPkg::qamSymbol_t txSymbol;	// Mapper to symFifo
	logic                     txWriteEnable;
	logic                     symFull;
	qamSymbolPkg::qamSymbol_t rxSymbol;	// symFifo to slicer
	logic                     symEmpty;
	logic                     rxReadEnable;
	qamStreamPkg::qamNibble_t slicedNibble;	// Slicer to outFifo
	logic                     slicedWriteEnable;
	logic                     outQueueFull;

	//////////////////////////////
	// Transmit side
	//////////////////////////////

	syncFifo #(
		.DEPTH     (`QAM_IN_DEPTH),
		.payload_t (qamStreamPkg::qamNibble_t)
	) inFifo (
		.inClock       (inClock),
		.rst           (rst),
		.inWriteEnable (inWriteEnable),
		.inData        (inData),
		.outFull       (outFull),
		.inReadEnable  (mapReadEnable),
		.outData       (mapNibble),
		.outEmpty      (mapEmpty)
	);

	qamMapper mapper (
		.inClock        (inClock),
		.rst            (rst),
		.inNibble       (mapNibble),
		.inEmpty        (mapEmpty),
		.outReadEnable  (mapReadEnable),
		.inFull         (symFull),
		.outWriteEnable (txWriteEnable),
		.outSymbol      (txSymbol)
	);

	// I and Q stay paired through the queue
	syncFifo #(
		.DEPTH     (`QAM_SYM_DEPTH),
		.payload_t (qamSymbolPkg::qamSymbol_t)
	) symFifo (
		.inClock       (inClock),
		.rst           (rst),
		.inWriteEnable (txWriteEnable),
		.inData        (txSymbol),
		.outFull       (symFull),
		.inReadEnable  (rxReadEnable),
		.outData       (rxSymbol),
		.outEmpty      (symEmpty)
	);

	//////////////////////////////
	// Receive side
	//////////////////////////////

	qamSlicer slicer (
		.inClock        (inClock),
		.rst            (rst),
		.inSymbol       (rxSymbol),
		.inEmpty        (symEmpty),
		.outReadEnable  (rxReadEnable),
		.inFull         (outQueueFull),
		.outWriteEnable (slicedWriteEnable),
		.outNibble      (slicedNibble),
		.outTxValid     (outTxValid),
		.outTxI         (outTxI),
		.outTxQ         (outTxQ)
	);

	syncFifo #(
		.DEPTH     (`QAM_OUT_DEPTH),
		.payload_t (qamStreamPkg::qamNibble_t)
	) outFifo (
		.inClock       (inClock),
		.rst           (rst),
		.inWriteEnable (slicedWriteEnable),
		.inData        (slicedNibble),
		.outFull       (outQueueFull),	// Back-pressure into the slicer
		.inReadEnable  (inReadEnable),
		.outData       (outData),
		.outEmpty      (outEmpty)
	);

endmodule

// File: bench/tb_qamLoopTop.sv
`timescale 1ns/1ps

module tb_qamLoopTop;

	localparam int STIM_N       = 20;	// Rows in the stimulus table
	localparam int DRAIN_LIMIT  = 300;	// Cycles allowed to empty the loop
	localparam int FILL_LIMIT   = 64;	// Cycles allowed to reach full
	localparam int RANDOM_CYCLES = 200;

	logic                     inClock;
	logic                     rst;
	logic                     inWriteEnable;
	qamStreamPkg::qamNibble_t inData;
	logic                     outFull;
	logic                     inReadEnable;
	qamStreamPkg::qamNibble_t outData;
	logic                     outEmpty;
	logic                     outTxValid;
	qamSymbolPkg::qamLevel_t  outTxI;
	qamSymbolPkg::qamLevel_t  outTxQ;

	// Gray levels indexed by bit pair 00, 01, 10, 11
	qamSymbolPkg::qamLevel_t grayLevel [4] = '{-4'sd3, -4'sd1, 4'sd3, 4'sd1};

	// Each row holds write flag, read flag and nibble
	logic [5:0] stimTable [STIM_N] = '{
		6'b11_0000, 6'b11_0001, 6'b11_0010, 6'b11_0011,
		6'b01_0000,	// Read only
		6'b11_0100, 6'b11_0101, 6'b11_0110, 6'b11_0111,
		6'b00_0000,	// Idle
		6'b11_1000, 6'b11_1001, 6'b11_1010, 6'b11_1011,
		6'b01_0000,
		6'b11_1100, 6'b11_1101, 6'b11_1110, 6'b11_1111,
		6'b01_0000
	};

	qamSymbolPkg::qamSymbol_t expSymbols [$];	// Scoreboard for the tap
	qamStreamPkg::qamNibble_t expNibbles [$];	// Scoreboard for outData
	int                       errorCount;
	int                       acceptedCount;
	int                       droppedCount;
	int                       waitCycles;
	logic [31:0]              rngState;
	logic [31:0]              rngWord;
	logic [5:0]               entry;
	qamStreamPkg::qamNibble_t fillNibble;

	qamLoopTop dut (
		.inClock       (inClock),
		.rst           (rst),
		.inWriteEnable (inWriteEnable),
		.inData        (inData),
		.outFull       (outFull),
		.inReadEnable  (inReadEnable),
		.outData       (outData),
		.outEmpty      (outEmpty),
		.outTxValid    (outTxValid),
		.outTxI        (outTxI),
		.outTxQ        (outTxQ)
	);

	initial begin
		inClock = 1'b0;
		forever #50 inClock = ~inClock;	// 100 ns period
	end

	//////////////////////////////
	// Helpers
	//////////////////////////////

	function automatic logic [31:0] nextRandom(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Expected constellation point of a nibble
	function automatic qamSymbolPkg::qamSymbol_t expectedSymbol(
		input qamStreamPkg::qamNibble_t nibble);
		qamSymbolPkg::qamSymbol_t sym;
		sym.i = grayLevel[nibble[3:2]];
		sym.q = grayLevel[nibble[1:0]];
		return sym;
	endfunction

	task automatic stopOnFailure();
		$display("*** FAILED ***");
		$fatal(1);
	endtask

	task automatic checkSymbol(input string name, input qamSymbolPkg::qamSymbol_t got,
		input qamSymbolPkg::qamSymbol_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic checkNibble(input string name, input qamStreamPkg::qamNibble_t got,
		input qamStreamPkg::qamNibble_t exp);
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			errorCount++;
			$display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
			stopOnFailure();
		end
	endtask

	//////////////////////////////
	// One clock of stimulus and checking
	//////////////////////////////

	// Starts and ends 1 ns after a rising edge
	task automatic runCycle(input logic wr, input qamStreamPkg::qamNibble_t nibble,
		input logic rd);
		logic                     readIssued;
		qamSymbolPkg::qamSymbol_t gotSym;
		readIssued    = rd && !outEmpty;	// Only pop a non-empty queue
		inWriteEnable = wr;
		inData        = nibble;
		inReadEnable  = readIssued;
		if (wr && !outFull) begin
			expSymbols.push_back(expectedSymbol(nibble));
			expNibbles.push_back(nibble);
			acceptedCount++;
		end else if (wr) begin
			droppedCount++;	// Ignored by a full queue
		end
		@(posedge inClock);
		#1;
		inWriteEnable = 1'b0;
		inReadEnable  = 1'b0;
		if (outTxValid) begin
			if (expSymbols.size() == 0) begin
				errorCount++;
				$display("Tap showed a symbol while no accepted nibble was pending");
				stopOnFailure();
			end else begin
				gotSym.i = outTxI;
				gotSym.q = outTxQ;
				checkSymbol("outTxI/outTxQ", gotSym, expSymbols.pop_front());
			end
		end
		if (readIssued) begin
			if (expNibbles.size() == 0) begin
				errorCount++;
				$display("Output queue returned a nibble that was never accepted");
				stopOnFailure();
			end else begin
				checkNibble("outData", outData, expNibbles.pop_front());
			end
		end
	endtask

	// Reads until every accepted nibble came back through tap and output
	task automatic drainOutput();
		int cycles;
		cycles = 0;
		while (expNibbles.size() != 0 || expSymbols.size() != 0) begin
			if (cycles == DRAIN_LIMIT) begin
				$display("Timeout: loop did not return all accepted nibbles");
				stopOnFailure();
			end
			runCycle(1'b0, 4'h0, 1'b1);
			cycles++;
		end
		repeat (3) runCycle(1'b0, 4'h0, 1'b0);	// Catch stray taps
		checkFlag("outEmpty", outEmpty, 1'b1);
		checkFlag("outFull", outFull, 1'b0);
	endtask

	//////////////////////////////
	// Main sequence
	//////////////////////////////

	initial begin
		rst           = 1'b1;
		inWriteEnable = 1'b0;
		inData        = '0;
		inReadEnable  = 1'b0;
		errorCount    = 0;
		acceptedCount = 0;
		droppedCount  = 0;
		rngState      = 32'h1d4f_7b4f;
		repeat (16) @(posedge inClock);
		#1;
		rst = 1'b0;

		// Idle state after reset
		checkFlag("outEmpty", outEmpty, 1'b1);
		checkFlag("outFull", outFull, 1'b0);
		checkFlag("outTxValid", outTxValid, 1'b0);

		// All sixteen nibbles in order
		for (int k = 0; k < STIM_N; k++) begin
			entry = stimTable[k];
			runCycle(entry[5], entry[3:0], entry[4]);
		end
		drainOutput();
		checkFlag("all sixteen accepted", acceptedCount == 16, 1'b1);

		// No reads until the input queue reports full
		fillNibble = 4'h3;
		waitCycles = 0;
		while (!outFull) begin
			if (waitCycles == FILL_LIMIT) begin
				$display("Timeout: input queue never reported full");
				stopOnFailure();
			end
			runCycle(1'b1, fillNibble, 1'b0);
			fillNibble = fillNibble + 4'h7;	// Walks through all values
			waitCycles++;
		end
		repeat (4) begin
			runCycle(1'b1, fillNibble, 1'b0);	// Must be dropped
			fillNibble = fillNibble + 4'h7;
			checkFlag("outFull", outFull, 1'b1);
		end
		drainOutput();

		// Random enables
		for (int k = 0; k < RANDOM_CYCLES; k++) begin
			rngState = nextRandom(rngState);
			rngWord  = rngState;
			runCycle(rngWord[0], rngWord[7:4], rngWord[1]);
		end
		drainOutput();

		$display("Accepted %0d nibbles, dropped %0d", acceptedCount, droppedCount);
		if (errorCount == 0) begin
			$display("*** PASSED ***");
			$finish;
		end else begin
			$display("*** FAILED ***");
			$fatal(1);
		end
	end

endmodule

// File: qamLoop.f
+incdir+include
hw/qamStreamPkg.sv
hw/qamSymbolPkg.sv
hw/syncFifo.sv
hw/qamMapper.sv
hw/qamSlicer.sv
hw/qamLoopTop.sv
bench/tb_qamLoopTop.sv

// File: Bender.yml
package:
  name: qamLoop

sources:
  # Design sources, packages first
  - include_dirs:
      - include
    files:
      - hw/qamStreamPkg.sv
      - hw/qamSymbolPkg.sv
      - hw/syncFifo.sv
      - hw/qamMapper.sv
      - hw/qamSlicer.sv
      - hw/qamLoopTop.sv

  # Testbench
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_qamLoopTop.sv
